/* rtl/cpu_pkg.sv */
package cpu_pkg;

    localparam int xlen       = 32;
    localparam int dmem_words = 64;
    localparam int dmem_aw    = $clog2(dmem_words);

    // RV32I major opcodes in the supported subset
    localparam logic [6:0] op_rtype  = 7'b0110011;
    localparam logic [6:0] op_itype  = 7'b0010011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_slt
    } alu_op_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    // Branch offset bits are scattered, bit 0 is implied zero
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
    } inst_u;

    typedef struct packed {
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    branch;
        logic    alu_src;
        alu_op_e alu_op;
    } ctrl_t;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
        inst_u           inst;
    } if_id_t;

    typedef struct packed {
        logic            valid;
        ctrl_t           ctrl;
        logic [xlen-1:0] pc;
        logic [xlen-1:0] rd1;
        logic [xlen-1:0] rd2;
        logic [xlen-1:0] imm;
        logic [4:0]      rs1;
        logic [4:0]      rs2;
        logic [4:0]      rd;
    } id_ex_t;

    typedef struct packed {
        logic            valid;
        ctrl_t           ctrl;
        logic [xlen-1:0] pc;
        logic [xlen-1:0] branch_target;
        logic            zero;
        logic [xlen-1:0] alu_result;
        logic [xlen-1:0] store_data;
        logic [4:0]      rd;
    } ex_mem_t;

    typedef struct packed {
        logic            valid;
        logic            reg_write;
        logic            mem_read;
        logic [xlen-1:0] pc;
        logic [xlen-1:0] read_data;
        logic [xlen-1:0] alu_result;
        logic [4:0]      rd;
    } mem_wb_t;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
        logic            reg_write;
        logic [4:0]      rd;
        logic [xlen-1:0] wdata;
    } retire_t;

endpackage

/* rtl/fetch_stage.sv */
`timescale 1ns/1ns

module fetch_stage import cpu_pkg::*; (
    input  logic            clk,
    input  logic            reset,
    input  logic            stall,
    input  logic            branch_taken,
    input  logic [xlen-1:0] branch_target,
    output logic [xlen-1:0] pc
);

    logic [xlen-1:0] pc_next;

    // Redirect wins over a load-use hold
    always_comb begin
        if (branch_taken) begin
            pc_next = branch_target;
        end else if (stall) begin
            pc_next = pc;
        end else begin
            pc_next = pc + xlen'(4);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
        end else begin
            pc <= pc_next;
        end
    end

    // Targets come from the execute adder, so alignment depends on decoded offsets
    pc_aligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00)
        else $error("fetch pc not word aligned: %h", pc);

endmodule

/* rtl/decode_stage.sv */
`timescale 1ns/1ns

module decode_stage import cpu_pkg::*; (
    input  logic            clk,
    input  logic            reset,
    input  if_id_t          if_id,
    input  logic            id_ex_mem_read,
    input  logic [4:0]      id_ex_rd,
    input  logic            wb_write,
    input  logic [4:0]      wb_rd,
    input  logic [xlen-1:0] wb_data,
    output id_ex_t          id_ex_next,
    output logic            stall
);

    logic [xlen-1:0] regs [32];
    inst_u           inst;
    ctrl_t           ctrl;
    logic [xlen-1:0] imm;
    logic [xlen-1:0] rd1;
    logic [xlen-1:0] rd2;

    assign inst = if_id.inst;

    // Register file, x0 is never written
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_write && wb_rd != 5'd0) begin
            regs[wb_rd] <= wb_data;
        end
    end

    // Write-first read so writeback is visible the same cycle
    assign rd1 = (inst.r.rs1 == 5'd0) ? '0 :
                 (wb_write && wb_rd == inst.r.rs1) ? wb_data : regs[inst.r.rs1];
    assign rd2 = (inst.r.rs2 == 5'd0) ? '0 :
                 (wb_write && wb_rd == inst.r.rs2) ? wb_data : regs[inst.r.rs2];

    always_comb begin
        ctrl        = '0;
        ctrl.alu_op = alu_add;
        case (inst.r.opcode)
            op_rtype: begin
                ctrl.reg_write = 1'b1;
                case ({inst.r.funct7[5], inst.r.funct3})
                    4'b0_000: ctrl.alu_op = alu_add;
                    4'b1_000: ctrl.alu_op = alu_sub;
                    4'b0_111: ctrl.alu_op = alu_and;
                    4'b0_110: ctrl.alu_op = alu_or;
                    4'b0_010: ctrl.alu_op = alu_slt;
                    default:  ctrl.reg_write = 1'b0;
                endcase
            end
            op_itype: begin
                ctrl.reg_write = (inst.i.funct3 == 3'b000);
                ctrl.alu_src   = 1'b1;
            end
            op_load: begin
                ctrl.reg_write = 1'b1;
                ctrl.mem_read  = 1'b1;
                ctrl.alu_src   = 1'b1;
            end
            op_store: begin
                ctrl.mem_write = 1'b1;
                ctrl.alu_src   = 1'b1;
            end
            op_branch: begin
                ctrl.branch = (inst.b.funct3 == 3'b000);
                ctrl.alu_op = alu_sub;
            end
            default: ;
        endcase
    end

    // Immediate by format, anything unlisted uses the I layout
    always_comb begin
        case (inst.r.opcode)
            op_store:  imm = {{(xlen-12){inst.s.imm_hi[6]}}, inst.s.imm_hi, inst.s.imm_lo};
            op_branch: imm = {{(xlen-12){inst.b.imm12}}, inst.b.imm11, inst.b.imm10_5,
                              inst.b.imm4_1, 1'b0};
            default:   imm = {{(xlen-12){inst.i.imm[11]}}, inst.i.imm};
        endcase
    end

    always_comb begin
        id_ex_next.valid = if_id.valid;
        id_ex_next.ctrl  = if_id.valid ? ctrl : '0;
        id_ex_next.pc    = if_id.pc;
        id_ex_next.rd1   = rd1;
        id_ex_next.rd2   = rd2;
        id_ex_next.imm   = imm;
        id_ex_next.rs1   = inst.r.rs1;
        id_ex_next.rs2   = inst.r.rs2;
        // No destination unless the instruction writes back
        id_ex_next.rd    = ctrl.reg_write ? inst.r.rd : 5'd0;
    end

    // Load in execute feeding the instruction in decode
    assign stall = if_id.valid && id_ex_mem_read && id_ex_rd != 5'd0 &&
                   (id_ex_rd == inst.r.rs1 || id_ex_rd == inst.r.rs2);

    x0_zero: assert property (@(posedge clk) disable iff (reset) regs[0] == '0)
        else $error("register x0 holds %h", regs[0]);

endmodule

/* rtl/execute_stage.sv */
`timescale 1ns/1ns

module execute_stage import cpu_pkg::*; (
    input  id_ex_t          id_ex,
    input  logic            ex_mem_fwd_write,
    input  logic [4:0]      ex_mem_fwd_rd,
    input  logic [xlen-1:0] ex_mem_fwd_data,
    input  logic            wb_write,
    input  logic [4:0]      wb_rd,
    input  logic [xlen-1:0] wb_data,
    output ex_mem_t         ex_mem_next
);

    logic            ex_hit_a;
    logic            ex_hit_b;
    logic            wb_hit_a;
    logic            wb_hit_b;
    logic [xlen-1:0] fwd_a;
    logic [xlen-1:0] fwd_b;
    logic [xlen-1:0] op_b;
    logic [xlen-1:0] diff;
    logic [xlen-1:0] alu_result;

    // Forwarding unit, the younger producer in ex_mem has priority
    assign ex_hit_a = ex_mem_fwd_write && ex_mem_fwd_rd != 5'd0 && ex_mem_fwd_rd == id_ex.rs1;
    assign ex_hit_b = ex_mem_fwd_write && ex_mem_fwd_rd != 5'd0 && ex_mem_fwd_rd == id_ex.rs2;
    assign wb_hit_a = wb_write && wb_rd != 5'd0 && wb_rd == id_ex.rs1;
    assign wb_hit_b = wb_write && wb_rd != 5'd0 && wb_rd == id_ex.rs2;

    assign fwd_a = ex_hit_a ? ex_mem_fwd_data : wb_hit_a ? wb_data : id_ex.rd1;
    assign fwd_b = ex_hit_b ? ex_mem_fwd_data : wb_hit_b ? wb_data : id_ex.rd2;

    assign op_b = id_ex.ctrl.alu_src ? id_ex.imm : fwd_b;
    assign diff = fwd_a - fwd_b;

    always_comb begin
        case (id_ex.ctrl.alu_op)
            alu_add: alu_result = fwd_a + op_b;
            alu_sub: alu_result = fwd_a - op_b;
            alu_and: alu_result = fwd_a & op_b;
            alu_or:  alu_result = fwd_a | op_b;
            alu_slt: alu_result = xlen'($signed(fwd_a) < $signed(op_b));
            default: alu_result = fwd_a + op_b;
        endcase
    end

    always_comb begin
        ex_mem_next.valid         = id_ex.valid;
        ex_mem_next.ctrl          = id_ex.ctrl;
        ex_mem_next.pc            = id_ex.pc;
        ex_mem_next.branch_target = id_ex.pc + id_ex.imm;
        // beq compares the register operands
        ex_mem_next.zero          = (diff == '0);
        ex_mem_next.alu_result    = alu_result;
        ex_mem_next.store_data    = fwd_b;
        ex_mem_next.rd            = id_ex.rd;
    end

endmodule

/* rtl/memory_stage.sv */
`timescale 1ns/1ns

module memory_stage import cpu_pkg::*; (
    input  logic    clk,
    input  ex_mem_t ex_mem,
    output logic    branch_taken,
    output mem_wb_t mem_wb_next
);

    logic [xlen-1:0]    dmem [dmem_words];
    logic [dmem_aw-1:0] dmem_idx;
    logic               do_store;

    initial begin
        for (int i = 0; i < dmem_words; i++) begin
            dmem[i] = '0;
        end
    end

    // Word index, the address wraps past the array
    assign dmem_idx = ex_mem.alu_result[dmem_aw+1:2];
    assign do_store = ex_mem.valid && ex_mem.ctrl.mem_write;

    always_ff @(posedge clk) begin
        if (do_store) begin
            dmem[dmem_idx] <= ex_mem.store_data;
        end
    end

    assign branch_taken = ex_mem.valid && ex_mem.ctrl.branch && ex_mem.zero;

    always_comb begin
        mem_wb_next.valid      = ex_mem.valid;
        mem_wb_next.reg_write  = ex_mem.ctrl.reg_write;
        mem_wb_next.mem_read   = ex_mem.ctrl.mem_read;
        mem_wb_next.pc         = ex_mem.pc;
        mem_wb_next.read_data  = dmem[dmem_idx];
        mem_wb_next.alu_result = ex_mem.alu_result;
        mem_wb_next.rd         = ex_mem.rd;
    end

    // Decode never builds an instruction that both loads and stores
    no_load_store: assert property (@(posedge clk)
        ex_mem.valid |-> !(ex_mem.ctrl.mem_read && ex_mem.ctrl.mem_write))
        else $error("load and store active together at pc %h", ex_mem.pc);

endmodule

/* rtl/cpu_top.sv */
`timescale 1ns/1ns

module cpu_top import cpu_pkg::*; (
    input  logic            clk,
    input  logic            reset,
    output logic [xlen-1:0] imem_addr,
    input  logic [xlen-1:0] imem_data,
    output retire_t         retire
);

    if_id_t          if_id;
    id_ex_t          id_ex;
    id_ex_t          id_ex_next;
    ex_mem_t         ex_mem;
    ex_mem_t         ex_mem_next;
    mem_wb_t         mem_wb;
    mem_wb_t         mem_wb_next;
    logic [xlen-1:0] pc;
    logic            stall;
    logic            branch_taken;
    logic            wb_write;
    logic [xlen-1:0] wb_data;

    assign imem_addr = pc;

    fetch_stage u_fetch (
        .clk           (clk),
        .reset         (reset),
        .stall         (stall),
        .branch_taken  (branch_taken),
        .branch_target (ex_mem.branch_target),
        .pc            (pc)
    );

    // IF/ID holds on stall, flushed on redirect
    always_ff @(posedge clk) begin
        if (reset || branch_taken) begin
            if_id.valid <= 1'b0;
        end else if (!stall) begin
            if_id.valid <= 1'b1;
            if_id.pc    <= pc;
            if_id.inst  <= imem_data;
        end
    end

    decode_stage u_decode (
        .clk            (clk),
        .reset          (reset),
        .if_id          (if_id),
        .id_ex_mem_read (id_ex.valid && id_ex.ctrl.mem_read),
        .id_ex_rd       (id_ex.rd),
        .wb_write       (wb_write),
        .wb_rd          (mem_wb.rd),
        .wb_data        (wb_data),
        .id_ex_next     (id_ex_next),
        .stall          (stall)
    );

    // Bubble into ID/EX on stall or flush
    always_ff @(posedge clk) begin
        if (reset || branch_taken || stall) begin
            id_ex.valid <= 1'b0;
            id_ex.ctrl  <= '0;
        end else begin
            id_ex <= id_ex_next;
        end
    end

    execute_stage u_execute (
        .id_ex            (id_ex),
        .ex_mem_fwd_write (ex_mem.valid && ex_mem.ctrl.reg_write && !ex_mem.ctrl.mem_read),
        .ex_mem_fwd_rd    (ex_mem.rd),
        .ex_mem_fwd_data  (ex_mem.alu_result),
        .wb_write         (wb_write),
        .wb_rd            (mem_wb.rd),
        .wb_data          (wb_data),
        .ex_mem_next      (ex_mem_next)
    );

    always_ff @(posedge clk) begin
        if (reset || branch_taken) begin
            ex_mem.valid <= 1'b0;
            ex_mem.ctrl  <= '0;
        end else begin
            ex_mem <= ex_mem_next;
        end
    end

    memory_stage u_memory (
        .clk          (clk),
        .ex_mem       (ex_mem),
        .branch_taken (branch_taken),
        .mem_wb_next  (mem_wb_next)
    );

    // The taken branch itself still moves on to writeback
    always_ff @(posedge clk) begin
        if (reset) begin
            mem_wb.valid     <= 1'b0;
            mem_wb.reg_write <= 1'b0;
            mem_wb.mem_read  <= 1'b0;
        end else begin
            mem_wb <= mem_wb_next;
        end
    end

    assign wb_write = mem_wb.valid && mem_wb.reg_write;
    assign wb_data  = mem_wb.mem_read ? mem_wb.read_data : mem_wb.alu_result;

    always_comb begin
        retire.valid     = mem_wb.valid;
        retire.pc        = mem_wb.pc;
        retire.reg_write = wb_write && mem_wb.rd != 5'd0;
        retire.rd        = mem_wb.rd;
        retire.wdata     = wb_data;
    end

endmodule

/* testbench/cpu_tb.sv */
`timescale 1ns/1ns

module cpu_tb import cpu_pkg::*; ();

    localparam int prog_words  = 64;
    localparam int num_retire  = 300;
    localparam int max_cycles  = 2000;

    logic            clk;
    logic            reset;
    logic [xlen-1:0] imem_addr;
    logic [xlen-1:0] imem_data;
    retire_t         retire;

    logic [31:0] prog [prog_words];
    logic [31:0] lfsr;
    int          errors;

    // ISA model state
    logic [31:0] mreg [32];
    logic [31:0] mmem [dmem_words];
    logic [31:0] mpc;

    cpu_top u_dut (
        .clk       (clk),
        .reset     (reset),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .retire    (retire)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Right-shift Galois LFSR with taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
        return v;
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, op_rtype};
    endfunction

    function automatic logic [31:0] enc_i(input logic [6:0] op, input logic [31:0] imm,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {imm[11:0], rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_s(input logic [31:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], op_store};
    endfunction

    function automatic logic [31:0] enc_b(input logic [31:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1);
        return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], op_branch};
    endfunction

    task automatic gen_program();
        logic [31:0] sel;
        logic [31:0] rop;
        logic [31:0] imm;
        logic [31:0] pair_imm;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  pair_rd;
        int          follow;
        follow   = 0;
        pair_imm = '0;
        pair_rd  = 5'd1;
        for (int i = 0; i < prog_words; i++) begin
            sel = rand_bits(4);
            rd  = 5'(rand_bits(3));
            rs1 = 5'(rand_bits(3));
            rs2 = 5'(rand_bits(3));
            if (follow == 1) begin
                // Load back the word that the store just wrote
                pair_rd = (rd == 5'd0) ? 5'd1 : rd;
                prog[i] = enc_i(op_load, pair_imm, 5'd0, 3'b010, pair_rd);
                follow  = 2;
            end else if (follow == 2) begin
                // Use of the loaded register right away
                prog[i] = enc_r(7'h00, rs2, pair_rd, 3'b000, rd);
                follow  = 0;
            end else if (sel < 5 || sel == 15) begin
                rop = rand_bits(3);
                if (rop > 4) rop = rop - 5;
                case (rop)
                    0:       prog[i] = enc_r(7'h00, rs2, rs1, 3'b000, rd);
                    1:       prog[i] = enc_r(7'h20, rs2, rs1, 3'b000, rd);
                    2:       prog[i] = enc_r(7'h00, rs2, rs1, 3'b111, rd);
                    3:       prog[i] = enc_r(7'h00, rs2, rs1, 3'b110, rd);
                    default: prog[i] = enc_r(7'h00, rs2, rs1, 3'b010, rd);
                endcase
            end else if (sel < 9) begin
                imm     = rand_bits(12);
                prog[i] = enc_i(op_itype, imm, rs1, 3'b000, rd);
            end else if (sel < 11) begin
                // Small window of words so loads often hit recent stores
                imm     = rand_bits(4) << 2;
                prog[i] = enc_i(op_load, imm, 5'd0, 3'b010, rd);
            end else if (sel < 13) begin
                imm      = rand_bits(4) << 2;
                prog[i]  = enc_s(imm, rs2, 5'd0);
                // Some stores get a load and a use right behind them
                rop      = rand_bits(1);
                follow   = rop[0] ? 1 : 0;
                pair_imm = imm;
            end else begin
                // Nonzero offsets of 8 to 32 bytes either way
                rop     = rand_bits(3);
                imm     = ((rop & 32'd3) + 32'd1) << 3;
                if (rop[2]) imm = -imm;
                prog[i] = enc_b(imm, rs2, rs1);
            end
        end
    endtask

    // Executes the next instruction in program order
    task automatic model_step(output logic exp_write, output logic [4:0] exp_rd,
                              output logic [31:0] exp_data);
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        logic [31:0] imm_b;
        logic [31:0] addr;
        logic [31:0] value;
        logic [31:0] next_pc;
        logic        writes;
        w       = prog[mpc[7:2]];
        a       = mreg[w[19:15]];
        b       = mreg[w[24:20]];
        imm_i   = {{20{w[31]}}, w[31:20]};
        imm_s   = {{20{w[31]}}, w[31:25], w[11:7]};
        imm_b   = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        next_pc = mpc + 32'd4;
        writes  = 1'b0;
        value   = '0;
        case (w[6:0])
            op_rtype: begin
                writes = 1'b1;
                case ({w[31:25], w[14:12]})
                    {7'h00, 3'b000}: value = a + b;
                    {7'h20, 3'b000}: value = a - b;
                    {7'h00, 3'b111}: value = a & b;
                    {7'h00, 3'b110}: value = a | b;
                    {7'h00, 3'b010}: value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default:         writes = 1'b0;
                endcase
            end
            op_itype: begin
                writes = (w[14:12] == 3'b000);
                value  = a + imm_i;
            end
            op_load: begin
                addr   = a + imm_i;
                writes = 1'b1;
                value  = mmem[addr[7:2]];
            end
            op_store: begin
                addr             = a + imm_s;
                mmem[addr[7:2]]  = b;
            end
            op_branch: begin
                if (w[14:12] == 3'b000 && a == b) next_pc = mpc + imm_b;
            end
            default: ;
        endcase
        exp_write = writes && (w[11:7] != 5'd0);
        exp_rd    = writes ? w[11:7] : 5'd0;
        exp_data  = value;
        if (exp_write) mreg[w[11:7]] = value;
        mpc = next_pc;
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL t=%0t %s: got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    initial begin
        int          cycles;
        int          retired;
        logic        exp_write;
        logic [4:0]  exp_rd;
        logic [31:0] exp_data;
        logic [31:0] exp_pc;
        errors = 0;
        lfsr   = 32'h6508;
        mpc    = '0;
        for (int i = 0; i < 32; i++) mreg[i] = '0;
        for (int i = 0; i < dmem_words; i++) mmem[i] = '0;
        reset = 1'b1;
        gen_program();
        imem_data = prog[0];

        repeat (5) begin
            @(posedge clk);
            #1;
            imem_data = prog[imem_addr[7:2]];
        end
        reset = 1'b0;
        check_value("retire.valid", 32'(retire.valid), 32'd0);
        check_value("imem_addr", imem_addr, 32'd0);

        cycles  = 0;
        retired = 0;
        while (retired < num_retire && cycles < max_cycles) begin
            @(posedge clk);
            #1;
            imem_data = prog[imem_addr[7:2]];
            cycles++;
            if (retire.valid) begin
                // First instruction cannot stall and takes exactly four cycles
                if (retired == 0) check_value("first_retire_cycle", 32'(cycles), 32'd4);
                exp_pc = mpc;
                model_step(exp_write, exp_rd, exp_data);
                check_value("retire.pc", retire.pc, exp_pc);
                check_value("retire.reg_write", 32'(retire.reg_write), 32'(exp_write));
                check_value("retire.rd", 32'(retire.rd), 32'(exp_rd));
                if (exp_write) check_value("retire.wdata", retire.wdata, exp_data);
                retired++;
            end
        end
        if (retired < num_retire) begin
            $display("Timeout: the processor stopped retiring after %0d instructions",
                     retired);
            errors++;
        end

        $display("Retired %0d instructions in %0d cycles with %0d errors",
                 retired, cycles, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* list.f */
rtl/cpu_pkg.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/memory_stage.sv
rtl/cpu_top.sv
testbench/cpu_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the cpu_tb simulation with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module cpu_tb \
    -Mdir obj_dir -o cpu_tb_sim > build.log 2>&1 || { cat build.log; exit 1; }

./obj_dir/cpu_tb_sim > sim.log 2>&1 || true
cat sim.log

grep -qx "TESTBENCH PASSED" sim.log && exit 0 || exit 1
